// File: files.f
source/mips_pkg.sv
source/reg_file.sv
source/id_stage.sv
source/ex_stage.sv
source/mips_core.sv
testbench/tb_mips_core.sv

// File: source/ex_stage.sv
//////////////////////////////////////////////////
// ex_stage
// logic, shift and arithmetic ALU with the
// execute to result register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                ex_valid_i,
	input  logic                ex_wreg_i,
	input  logic                ex_illegal_i,
	input  mips_pkg::alu_op_e   ex_aluop_i,
	input  mips_pkg::alu_sel_e  ex_alusel_i,
	input  mips_pkg::word_t     ex_reg1_i,
	input  mips_pkg::word_t     ex_reg2_i,
	input  mips_pkg::reg_addr_t ex_wd_i,
	output logic                fwd_ex_wreg_o,
	output mips_pkg::reg_addr_t fwd_ex_wd_o,
	output mips_pkg::word_t     fwd_ex_wdata_o,
	output logic                wb_valid_o,
	output mips_pkg::reg_addr_t wb_addr_o,
	output mips_pkg::word_t     wb_data_o,
	output logic                illegal_o
);

	import mips_pkg::*;

	logic [SHAMT_W-1:0] shamt;
	word_t logic_res;
	word_t shift_res;
	word_t arith_res;
	word_t result;

	assign shamt = ex_reg1_i[SHAMT_W-1:0];

	always_comb begin
		case (ex_aluop_i)
			ALU_OR:  logic_res = ex_reg1_i | ex_reg2_i;
			ALU_AND: logic_res = ex_reg1_i & ex_reg2_i;
			ALU_XOR: logic_res = ex_reg1_i ^ ex_reg2_i;
			ALU_NOR: logic_res = ~(ex_reg1_i | ex_reg2_i);
			default: logic_res = '0;
		endcase
	end

	always_comb begin
		case (ex_aluop_i)
			ALU_SLL: shift_res = ex_reg2_i << shamt;
			ALU_SRL: shift_res = ex_reg2_i >> shamt;
			ALU_SRA: shift_res = word_t'($signed(ex_reg2_i) >>> shamt);
			default: shift_res = '0;
		endcase
	end

	always_comb begin
		case (ex_aluop_i)
			ALU_SLT:  arith_res = word_t'($signed(ex_reg1_i) < $signed(ex_reg2_i));
			ALU_SLTU: arith_res = word_t'(ex_reg1_i < ex_reg2_i);
			ALU_ADD:  arith_res = ex_reg1_i + ex_reg2_i;   // wraps
			ALU_SUB:  arith_res = ex_reg1_i - ex_reg2_i;
			default:  arith_res = '0;
		endcase
	end

	always_comb begin
		case (ex_alusel_i)
			SEL_LOGIC: result = logic_res;
			SEL_SHIFT: result = shift_res;
			SEL_ARITH: result = arith_res;
			default:   result = '0;
		endcase
	end

	// result of the instruction now in execute, back to decode
	assign fwd_ex_wreg_o  = ex_valid_i & ex_wreg_i;
	assign fwd_ex_wd_o    = ex_wd_i;
	assign fwd_ex_wdata_o = result;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_valid_o <= 1'b0;
			illegal_o  <= 1'b0;
		end else begin
			wb_valid_o <= ex_valid_i & ex_wreg_i;
			illegal_o  <= ex_valid_i & ex_illegal_i;  // one cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid_i) begin
			wb_addr_o <= ex_wd_i;
			wb_data_o <= result;
		end
	end

endmodule

// File: source/id_stage.sv
//////////////////////////////////////////////////
// id_stage
// instruction decode, immediates, operand forwarding
// and the decode to execute pipeline register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module id_stage (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                inst_valid_i,
	input  mips_pkg::word_t     inst_i,
	output mips_pkg::reg_addr_t reg1_addr_o,
	output mips_pkg::reg_addr_t reg2_addr_o,
	input  mips_pkg::word_t     reg1_data_i,
	input  mips_pkg::word_t     reg2_data_i,
	input  logic                fwd_ex_wreg_i,
	input  mips_pkg::reg_addr_t fwd_ex_wd_i,
	input  mips_pkg::word_t     fwd_ex_wdata_i,
	input  logic                fwd_wb_valid_i,
	input  mips_pkg::reg_addr_t fwd_wb_addr_i,
	input  mips_pkg::word_t     fwd_wb_data_i,
	output logic                ex_valid_o,
	output logic                ex_wreg_o,
	output logic                ex_illegal_o,
	output mips_pkg::alu_op_e   ex_aluop_o,
	output mips_pkg::alu_sel_e  ex_alusel_o,
	output mips_pkg::word_t     ex_reg1_o,
	output mips_pkg::word_t     ex_reg2_o,
	output mips_pkg::reg_addr_t ex_wd_o
);

	import mips_pkg::*;

	opcode_e        op;
	funct_e         funct;
	reg_addr_t      rs;
	reg_addr_t      rt;
	reg_addr_t      rd;
	logic [SHAMT_W-1:0] sa;
	logic [15:0]    imm16;

	alu_op_e        aluop;
	alu_sel_e       alusel;
	reg_addr_t      wd;
	logic           wreg;
	logic           inst_ok;
	logic           rd1_en;        // operand 1 from rs
	logic           rd2_en;        // operand 2 from rt
	word_t          imm;
	word_t          reg1_val;
	word_t          reg2_val;

	assign op    = opcode_e'(inst_i[31:26]);
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign sa    = inst_i[10:6];
	assign funct = funct_e'(inst_i[5:0]);
	assign imm16 = inst_i[15:0];

	assign reg1_addr_o = rs;
	assign reg2_addr_o = rt;

	// newest pending write wins
	function automatic word_t fwd_mux(input logic rd_en, input reg_addr_t addr,
			input word_t rf_data, input word_t imm_val);
		word_t val;
		if (!rd_en) begin
			val = imm_val;
		end else if (fwd_ex_wreg_i && (fwd_ex_wd_i == addr)) begin
			val = fwd_ex_wdata_i;
		end else if (fwd_wb_valid_i && (fwd_wb_addr_i == addr)) begin
			val = fwd_wb_data_i;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	always_comb begin
		aluop    = ALU_NOP;
		alusel   = SEL_NOP;
		wd       = rd;
		inst_ok  = 1'b1;
		rd1_en   = 1'b1;
		rd2_en   = 1'b0;
		imm      = '0;
		case (op)
			OP_SPECIAL: begin
				rd2_en  = 1'b1;
				inst_ok = (sa == '0);  // register forms keep sa zero
				case (funct)
					F_OR, F_AND, F_XOR, F_NOR: begin
						alusel = SEL_LOGIC;
						aluop  = (funct == F_OR)  ? ALU_OR  :
						         (funct == F_AND) ? ALU_AND :
						         (funct == F_XOR) ? ALU_XOR : ALU_NOR;
					end
					F_SLLV, F_SRLV, F_SRAV: begin
						alusel = SEL_SHIFT;
						aluop  = (funct == F_SLLV) ? ALU_SLL :
						         (funct == F_SRLV) ? ALU_SRL : ALU_SRA;
					end
					F_SLL, F_SRL, F_SRA: begin
						alusel  = SEL_SHIFT;
						aluop   = (funct == F_SLL) ? ALU_SLL :
						          (funct == F_SRL) ? ALU_SRL : ALU_SRA;
						rd1_en  = 1'b0;    // shift amount from sa
						imm     = word_t'(sa);
						inst_ok = (rs == '0);
					end
					F_SLT, F_SLTU, F_ADDU, F_SUBU: begin
						alusel = SEL_ARITH;
						aluop  = (funct == F_SLT)  ? ALU_SLT  :
						         (funct == F_SLTU) ? ALU_SLTU :
						         (funct == F_ADDU) ? ALU_ADD  : ALU_SUB;
					end
					default: begin
						inst_ok = 1'b0;
					end
				endcase
			end
			OP_ORI, OP_ANDI, OP_XORI: begin
				alusel = SEL_LOGIC;
				aluop  = (op == OP_ORI)  ? ALU_OR  :
				         (op == OP_ANDI) ? ALU_AND : ALU_XOR;
				wd     = rt;
				imm    = {16'h0000, imm16};  // zero extended
			end
			OP_LUI: begin
				alusel = SEL_LOGIC;
				aluop  = ALU_OR;         // imm | imm
				wd     = rt;
				rd1_en = 1'b0;
				imm    = {imm16, 16'h0000};
			end
			OP_SLTI, OP_SLTIU, OP_ADDIU: begin
				alusel = SEL_ARITH;
				aluop  = (op == OP_SLTI)  ? ALU_SLT  :
				         (op == OP_SLTIU) ? ALU_SLTU : ALU_ADD;
				wd     = rt;
				imm    = {{16{imm16[15]}}, imm16};  // sign extended
			end
			default: begin
				inst_ok = 1'b0;
			end
		endcase
	end

	// r0 is never a write target
	assign wreg = inst_ok & (wd != '0);

	always_comb begin
		reg1_val = fwd_mux(rd1_en, rs, reg1_data_i, imm);
		reg2_val = fwd_mux(rd2_en, rt, reg2_data_i, imm);
	end

	//////////////////////////////////////////////////
	// decode to execute register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_valid_o   <= 1'b0;
			ex_wreg_o    <= 1'b0;
			ex_illegal_o <= 1'b0;
		end else begin
			ex_valid_o   <= inst_valid_i;
			ex_wreg_o    <= inst_valid_i & wreg;
			ex_illegal_o <= inst_valid_i & ~inst_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid_i) begin
			ex_aluop_o  <= aluop;
			ex_alusel_o <= inst_ok ? alusel : SEL_NOP;
			ex_reg1_o   <= reg1_val;
			ex_reg2_o   <= reg2_val;
			ex_wd_o     <= wd;
		end
	end

endmodule

// File: source/mips_core.sv
//////////////////////////////////////////////////
// mips_core
// three-stage integer datapath, decode, execute
// and result with register file
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mips_core (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                inst_valid_i,
	input  mips_pkg::word_t     inst_i,
	output logic                wb_valid_o,
	output mips_pkg::reg_addr_t wb_addr_o,
	output mips_pkg::word_t     wb_data_o,
	output logic                illegal_o
);

	import mips_pkg::*;

	reg_addr_t reg1_addr;
	reg_addr_t reg2_addr;
	word_t     reg1_data;
	word_t     reg2_data;

	logic      ex_valid;
	logic      ex_wreg;
	logic      ex_illegal;
	alu_op_e   ex_aluop;
	alu_sel_e  ex_alusel;
	word_t     ex_reg1;
	word_t     ex_reg2;
	reg_addr_t ex_wd;

	logic      fwd_ex_wreg;
	reg_addr_t fwd_ex_wd;
	word_t     fwd_ex_wdata;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;

	id_stage u_id_stage (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.inst_valid_i   (inst_valid_i),
		.inst_i         (inst_i),
		.reg1_addr_o    (reg1_addr),
		.reg2_addr_o    (reg2_addr),
		.reg1_data_i    (reg1_data),
		.reg2_data_i    (reg2_data),
		.fwd_ex_wreg_i  (fwd_ex_wreg),
		.fwd_ex_wd_i    (fwd_ex_wd),
		.fwd_ex_wdata_i (fwd_ex_wdata),
		.fwd_wb_valid_i (wb_valid),
		.fwd_wb_addr_i  (wb_addr),
		.fwd_wb_data_i  (wb_data),
		.ex_valid_o     (ex_valid),
		.ex_wreg_o      (ex_wreg),
		.ex_illegal_o   (ex_illegal),
		.ex_aluop_o     (ex_aluop),
		.ex_alusel_o    (ex_alusel),
		.ex_reg1_o      (ex_reg1),
		.ex_reg2_o      (ex_reg2),
		.ex_wd_o        (ex_wd)
	);

	ex_stage u_ex_stage (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.ex_valid_i     (ex_valid),
		.ex_wreg_i      (ex_wreg),
		.ex_illegal_i   (ex_illegal),
		.ex_aluop_i     (ex_aluop),
		.ex_alusel_i    (ex_alusel),
		.ex_reg1_i      (ex_reg1),
		.ex_reg2_i      (ex_reg2),
		.ex_wd_i        (ex_wd),
		.fwd_ex_wreg_o  (fwd_ex_wreg),
		.fwd_ex_wd_o    (fwd_ex_wd),
		.fwd_ex_wdata_o (fwd_ex_wdata),
		.wb_valid_o     (wb_valid),
		.wb_addr_o      (wb_addr),
		.wb_data_o      (wb_data),
		.illegal_o      (illegal_o)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.we_i     (wb_valid),     // written one edge after the pulse
		.waddr_i  (wb_addr),
		.wdata_i  (wb_data),
		.raddr1_i (reg1_addr),
		.raddr2_i (reg2_addr),
		.rdata1_o (reg1_data),
		.rdata2_o (reg2_data)
	);

	assign wb_valid_o = wb_valid;
	assign wb_addr_o  = wb_addr;
	assign wb_data_o  = wb_data;

endmodule

// File: source/mips_pkg.sv
//////////////////////////////////////////////////
// mips_pkg
// widths, types and encodings shared by the
// decode, execute and register file blocks
//////////////////////////////////////////////////

package mips_pkg;

	localparam int WORD_W     = 32;            // data and instruction width
	localparam int REG_ADDR_W = 5;
	localparam int REG_NUM    = 1 << REG_ADDR_W; // 32 general registers
	localparam int SHAMT_W    = 5;             // shift amount field

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	//////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////

	// major opcode, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	// SPECIAL function field, inst[5:0]
	typedef enum logic [5:0] {
		F_SLL  = 6'b000000,
		F_SRL  = 6'b000010,
		F_SRA  = 6'b000011,
		F_SLLV = 6'b000100,
		F_SRLV = 6'b000110,
		F_SRAV = 6'b000111,
		F_ADDU = 6'b100001,
		F_SUBU = 6'b100011,
		F_AND  = 6'b100100,
		F_OR   = 6'b100101,
		F_XOR  = 6'b100110,
		F_NOR  = 6'b100111,
		F_SLT  = 6'b101010,
		F_SLTU = 6'b101011
	} funct_e;

	//////////////////////////////////////////////////
	// execute controls
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_NOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_ADD,                 // wrapping, no trap
		ALU_SUB
	} alu_op_e;

	// result class picks which unit drives the write data
	typedef enum logic [1:0] {
		SEL_NOP,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_ARITH
	} alu_sel_e;

endpackage

// File: source/reg_file.sv
//////////////////////////////////////////////////
// reg_file
// 32 x 32 register file, one write port and
// two combinational read ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

module reg_file (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                we_i,
	input  mips_pkg::reg_addr_t waddr_i,
	input  mips_pkg::word_t     wdata_i,
	input  mips_pkg::reg_addr_t raddr1_i,
	input  mips_pkg::reg_addr_t raddr2_i,
	output mips_pkg::word_t     rdata1_o,
	output mips_pkg::word_t     rdata2_o
);

	import mips_pkg::*;

	word_t regs [REG_NUM];

	// r0 stays zero, decode never enables a write to it
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];   // no bypass here

endmodule

// File: testbench/alu_patterns.hex
// columns: instruction, illegal flag, expected dest, expected data
// illegal rows and r0 targets expect no write pulse
// logic and lui, first row shows registers start at zero
34011234 0 01 00001234
3C028765 0 02 87650000
34424321 0 02 87654321
3043FF0F 0 03 00004301
3844FFFF 0 04 8765BCDE
00232825 0 05 00005335
00443024 0 06 87650000
00443826 0 07 0000FFFF
00204027 0 08 FFFFEDCB
// shifts, immediate and variable
00024900 0 09 76543210
00025202 0 0A 00876543
00025A03 0 0B FF876543
240C0024 0 0C 00000024
01826804 0 0D 76543210
01847006 0 0E 08765BCD
01847807 0 0F F8765BCD
000287C3 0 10 FFFFFFFF
// compares
0041882A 0 11 00000001
0041902B 0 12 00000000
2853FFFF 0 13 00000001
2C548000 0 14 00000001
2C350010 0 15 00000000
// wrapping add and subtract
26160001 0 16 00000000
0042B821 0 17 0ECA8642
0022C023 0 18 789ACF13
24198000 0 19 FFFF8000
// dependent chain
241A0005 0 1A 00000005
035AD021 0 1A 0000000A
001AD880 0 1B 00000028
037AE023 0 1C 0000001E
3B9D00FF 0 1D 000000E1
033DF02A 0 1E 00000001
// illegal encodings and r0 targets
8C220004 1 00 00000000
00221820 1 00 00000000
34200F0F 0 00 00000000
0002F821 0 1F 87654321
00600825 0 01 00004301
00000000 0 00 00000000
00232865 1 00 00000000

// File: testbench/tb_mips_core.sv
//////////////////////////////////////////////////
// tb_mips_core
// replays the pattern file through the datapath
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mips_core;

	import mips_pkg::*;

	localparam int          PAT_NUM     = 39;
	localparam int          PAT_FIELDS  = 4;   // inst, illegal, dest, data
	localparam int          DRAIN_LIMIT = 50;  // cycles
	localparam logic [31:0] LFSR_SEED   = 32'ha421_7472;

	logic      clk;
	logic      arst_n_i;
	logic      inst_valid_i;
	word_t     inst_i;
	logic      wb_valid_o;
	reg_addr_t wb_addr_o;
	word_t     wb_data_o;
	logic      illegal_o;

	logic [31:0] pat_mem [PAT_NUM*PAT_FIELDS];
	logic [31:0] lfsr_state;
	int          pass_num;
	logic        gap_lo;
	logic        gap_hi;

	// results in flight, oldest first
	logic      exp_ill_q  [$];
	reg_addr_t exp_addr_q [$];
	word_t     exp_data_q [$];
	int        exp_idx_q  [$];

	logic      exp_ill;
	reg_addr_t exp_addr;
	word_t     exp_data;
	int        exp_idx;
	string     seen_name;

	mips_core UUT (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.wb_valid_o   (wb_valid_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o),
		.illegal_o    (illegal_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	task automatic take_bit(output logic b);
		b = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	endtask

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic stop_with(input string why);
		$display("%s", why);
		abort_run();
	endtask

	task automatic check_equal(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		arst_n_i     = 1'b0;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		repeat (16) @(posedge clk);
		#1;
		arst_n_i = 1'b1;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#1;
		inst_valid_i = 1'b0;
		inst_i       = '0;
	endtask

	task automatic issue_pattern(input int idx);
		logic      ill;
		reg_addr_t dest;
		word_t     data;
		ill  = pat_mem[idx*PAT_FIELDS+1][0];
		dest = pat_mem[idx*PAT_FIELDS+2][REG_ADDR_W-1:0];
		data = pat_mem[idx*PAT_FIELDS+3];
		@(posedge clk);
		#1;
		inst_valid_i = 1'b1;
		inst_i       = pat_mem[idx*PAT_FIELDS];
		if (ill || (dest != '0)) begin   // r0 writes stay silent
			exp_ill_q.push_back(ill);
			exp_addr_q.push_back(dest);
			exp_data_q.push_back(data);
			exp_idx_q.push_back(idx);
		end
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		drive_idle();
		while (exp_ill_q.size() != 0) begin
			if (waited >= DRAIN_LIMIT) begin
				stop_with("timeout: pending results never showed up on the outputs");
			end
			@(posedge clk);
			waited++;
		end
		repeat (4) @(posedge clk);   // room for a stray pulse
	endtask

	//////////////////////////////////////////////////
	// output monitor
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (wb_valid_o || illegal_o) begin
			if (exp_ill_q.size() == 0) begin
				stop_with($sformatf("output pulse with nothing expected, wb_valid_o=%b illegal_o=%b",
					wb_valid_o, illegal_o));
			end else begin
				exp_ill   = exp_ill_q.pop_front();
				exp_addr  = exp_addr_q.pop_front();
				exp_data  = exp_data_q.pop_front();
				exp_idx   = exp_idx_q.pop_front();
				seen_name = $sformatf("pass %0d pattern %0d", pass_num, exp_idx);
				check_equal({seen_name, " illegal"}, exp_ill, illegal_o);
				check_equal({seen_name, " wb_valid"}, !exp_ill, wb_valid_o);
				if (!exp_ill) begin
					check_equal({seen_name, " addr"}, exp_addr, wb_addr_o);
					check_equal({seen_name, " data"}, exp_data, wb_data_o);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial begin
		arst_n_i     = 1'b0;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		lfsr_state   = LFSR_SEED;
		pass_num     = 0;
		$readmemh("testbench/alu_patterns.hex", pat_mem);
		if ($isunknown(pat_mem[PAT_NUM*PAT_FIELDS-1])) begin
			stop_with("pattern file is missing or shorter than expected");
		end
		// pass 0 back to back, pass 1 with random gaps
		for (int pass = 0; pass < 2; pass++) begin
			pass_num = pass;
			apply_reset();
			repeat (2) @(negedge clk);
			check_equal("after reset wb_valid_o", 32'd0, wb_valid_o);
			check_equal("after reset illegal_o", 32'd0, illegal_o);
			for (int i = 0; i < PAT_NUM; i++) begin
				issue_pattern(i);
				if (pass == 1) begin
					take_bit(gap_lo);
					take_bit(gap_hi);
					repeat ({gap_hi, gap_lo}) drive_idle();
				end
			end
			drain_pipeline();
		end
		if (exp_ill_q.size() != 0) begin
			stop_with("results still pending at the end of the run");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule
